//--- design/axiLiteSlave.sv
// AXI4-Lite slave FSM
`timescale 1ns/100ps
`default_nettype none

`include "ethRegs_consts.svh"

module axiLiteSlave (
  input  logic                             axiClk,
  input  logic                             rstN,
  // write address and data
  input  logic                             awValid,
  output logic                             awReady,
  input  logic [`ETH_REGS_AXI_ADDR_W-1:0]  awAddr,
  input  logic                             wValid,
  output logic                             wReady,
  input  ethRegsPkg::axiData_t             wData,
  // write response
  output logic                             bValid,
  output logic [1:0]                       bResp,
  input  logic                             bReady,
  // read address and data
  input  logic                             arValid,
  output logic                             arReady,
  input  logic [`ETH_REGS_AXI_ADDR_W-1:0]  arAddr,
  output logic                             rValid,
  output logic [1:0]                       rResp,
  input  logic                             rReady,
  // busy level from mdcClk domain
  input  logic                             mdioBusy,
  // to register file and read mux
  output ethRegsPkg::regWrite_t            regWr,
  output ethRegsPkg::regIdx_t              rdIdx
);

  import ethRegsPkg::*;

  busState_t state;

  // busy crossing
  logic      busyMeta;
  logic      busySync;

  // word indices out of the byte addresses
  regIdx_t   awIdx;
  regIdx_t   arIdx;

  // acceptance in idle
  logic      wrTake;
  logic      rdTake;

  // latched write
  logic      wrStrobe;
  regIdx_t   wrIdx;
  axiData_t  wrData;

  // ==========================================================================
  // busy synchronizer
  // ==========================================================================
  // seen 2 to 3 axiClk cycles late
  always_ff @(posedge axiClk or negedge rstN) begin
    if (!rstN) begin
      busyMeta <= 1'b0;
      busySync <= 1'b0;
    end else begin
      busyMeta <= mdioBusy;
      busySync <= busyMeta;
    end
  end

  // ==========================================================================
  // transaction FSM
  // ==========================================================================
  assign awIdx = awAddr[`ETH_REGS_IDX_MSB:`ETH_REGS_IDX_LSB];
  assign arIdx = arAddr[`ETH_REGS_IDX_MSB:`ETH_REGS_IDX_LSB];

  // write wins over read
  // nothing taken while busy
  assign wrTake = (state == idleSt) && awValid && wValid && !busySync;
  assign rdTake = (state == idleSt) && arValid && !busySync && !wrTake;

  always_ff @(posedge axiClk or negedge rstN) begin
    if (!rstN) begin
      state    <= idleSt;
      awReady  <= 1'b0;
      wReady   <= 1'b0;
      arReady  <= 1'b0;
      bValid   <= 1'b0;
      rValid   <= 1'b0;
      wrStrobe <= 1'b0;
      rdIdx    <= '0;
    end else begin
      // strobe is one cycle only
      wrStrobe <= 1'b0;
      case (state)
        idleSt: begin
          if (wrTake) begin
            awReady <= 1'b1;
            wReady  <= 1'b1;
            state   <= writeSt;
          end else if (rdTake) begin
            arReady <= 1'b1;
            rdIdx   <= arIdx;
            state   <= readSt;
          end
        end
        writeSt: begin
          // register updates on the edge after this
          awReady  <= 1'b0;
          wReady   <= 1'b0;
          wrStrobe <= 1'b1;
          bValid   <= 1'b1;
          state    <= ackSt;
        end
        readSt: begin
          arReady <= 1'b0;
          rValid  <= 1'b1;
          state   <= ackSt;
        end
        ackSt: begin
          // hold response until master takes it
          if (bValid && bReady) begin
            bValid <= 1'b0;
            state  <= idleSt;
          end
          if (rValid && rReady) begin
            rValid <= 1'b0;
            state  <= idleSt;
          end
        end
        default: begin
          state <= idleSt;
        end
      endcase
    end
  end

  // write payload captured at acceptance
  always_ff @(posedge axiClk or negedge rstN) begin
    if (!rstN) begin
      wrIdx  <= '0;
      wrData <= '0;
    end else if (wrTake) begin
      wrIdx  <= awIdx;
      wrData <= wData;
    end
  end

  assign regWr = '{strobe: wrStrobe, idx: wrIdx, data: wrData};

  // only OKAY is ever returned
  assign bResp = `ETH_REGS_RESP_OKAY;
  assign rResp = `ETH_REGS_RESP_OKAY;

endmodule

`default_nettype wire

//--- design/ethRegs.sv
// Ethernet MAC register block
`timescale 1ns/100ps
`default_nettype none

`include "ethRegs_consts.svh"

module ethRegs (
  input  logic                            axiClk,
  input  logic                            mdcClk,
  input  logic                            rstN,
  // AXI4-Lite slave port
  input  logic                            awValid,
  output logic                            awReady,
  input  logic [`ETH_REGS_AXI_ADDR_W-1:0] awAddr,
  input  logic                            wValid,
  output logic                            wReady,
  input  ethRegsPkg::axiData_t            wData,
  output logic                            bValid,
  output logic [1:0]                      bResp,
  input  logic                            bReady,
  input  logic                            arValid,
  output logic                            arReady,
  input  logic [`ETH_REGS_AXI_ADDR_W-1:0] arAddr,
  output logic                            rValid,
  output ethRegsPkg::axiData_t            rData,
  output logic [1:0]                      rResp,
  input  logic                            rReady,
  // MDIO engine, request on axiClk, response on mdcClk
  output ethRegsPkg::mdioReq_t            mdioReq,
  input  ethRegsPkg::mdioResp_t           mdioResp,
  // transmit test
  output logic                            ethTxTestEn
);

  import ethRegsPkg::*;

  regWrite_t                        regWr;
  regIdx_t                          rdIdx;
  axiData_t [`ETH_REGS_NUM_USR-1:0] usrRegs;
  axiData_t [`ETH_REGS_NUM_PHY-1:0] phyRegs;

  // bus side, busy crosses in here
  axiLiteSlave i_axiLiteSlave (
    .axiClk   (axiClk),
    .rstN     (rstN),
    .awValid  (awValid),
    .awReady  (awReady),
    .awAddr   (awAddr),
    .wValid   (wValid),
    .wReady   (wReady),
    .wData    (wData),
    .bValid   (bValid),
    .bResp    (bResp),
    .bReady   (bReady),
    .arValid  (arValid),
    .arReady  (arReady),
    .arAddr   (arAddr),
    .rValid   (rValid),
    .rResp    (rResp),
    .rReady   (rReady),
    .mdioBusy (mdioResp.busy),
    .regWr    (regWr),
    .rdIdx    (rdIdx)
  );

  userRegFile i_userRegFile (
    .axiClk      (axiClk),
    .rstN        (rstN),
    .regWr       (regWr),
    .usrRegs     (usrRegs),
    .mdioReq     (mdioReq),
    .ethTxTestEn (ethTxTestEn)
  );

  // mdcClk domain
  phyShadowRegs i_phyShadowRegs (
    .mdcClk   (mdcClk),
    .rstN     (rstN),
    .mdioResp (mdioResp),
    .phyRegs  (phyRegs)
  );

  regReadMux i_regReadMux (
    .rdIdx   (rdIdx),
    .usrRegs (usrRegs),
    .phyRegs (phyRegs),
    .rData   (rData)
  );

endmodule

`default_nettype wire

//--- design/ethRegsPkg.sv
// Ethernet register block types
`default_nettype none

`include "ethRegs_consts.svh"

package ethRegsPkg;

  // plain vectors with a meaning
  typedef logic [`ETH_REGS_AXI_DATA_W-1:0]  axiData_t;
  typedef logic [`ETH_REGS_IDX_W-1:0]       regIdx_t;
  typedef logic [`ETH_REGS_PHY_ADDR_W-1:0]  phyAddr_t;
  typedef logic [`ETH_REGS_MDIO_DATA_W-1:0] mdioData_t;

  // AXI transaction FSM
  typedef enum logic [1:0] {
    idleSt,
    readSt,
    writeSt,
    ackSt
  } busState_t;

  // toward the MDIO engine, levels only
  typedef struct packed {
    phyAddr_t  regAddr;
    phyAddr_t  phyAddr;
    logic      isWrite;
    logic      enable;
    mdioData_t wrData;
  } mdioReq_t;

  // from the MDIO engine, mdcClk domain
  // regIdx and data only valid with the strobe
  typedef struct packed {
    regIdx_t  regIdx;
    logic     valid;
    axiData_t data;
    logic     busy;
  } mdioResp_t;

  // internal one-cycle register write
  typedef struct packed {
    logic     strobe;
    regIdx_t  idx;
    axiData_t data;
  } regWrite_t;

endpackage

`default_nettype wire

//--- design/phyShadowRegs.sv
// PHY shadow registers
`timescale 1ns/100ps
`default_nettype none

`include "ethRegs_consts.svh"

module phyShadowRegs (
  input  logic                                          mdcClk,
  input  logic                                          rstN,
  input  ethRegsPkg::mdioResp_t                         mdioResp,
  // slots in ascending PHY index order
  output ethRegsPkg::axiData_t [`ETH_REGS_NUM_PHY-1:0] phyRegs
);

  // slot of the incoming index
  logic [$clog2(`ETH_REGS_NUM_PHY)-1:0] capSlot;
  // index names a PHY register
  logic                                 capHit;

  // ==========================================================================
  // index decode
  // ==========================================================================
  // each shadow at its own index
  always_comb begin
    capHit  = 1'b1;
    capSlot = '0;
    case (mdioResp.regIdx)
      `ETH_REGS_IDX_PHY_CTRL:      capSlot = 4'd0;
      `ETH_REGS_IDX_PHY_STAT:      capSlot = 4'd1;
      `ETH_REGS_IDX_PHY_IDENT_1:   capSlot = 4'd2;
      `ETH_REGS_IDX_PHY_IDENT_2:   capSlot = 4'd3;
      `ETH_REGS_IDX_PHY_ANA:       capSlot = 4'd4;
      `ETH_REGS_IDX_PHY_ANLP:      capSlot = 4'd5;
      `ETH_REGS_IDX_PHY_ANE:       capSlot = 4'd6;
      // vendor specific block
      `ETH_REGS_IDX_PHY_MODE:      capSlot = 4'd7;
      `ETH_REGS_IDX_PHY_SPEC_MD:   capSlot = 4'd8;
      `ETH_REGS_IDX_PHY_SYM_ERR:   capSlot = 4'd9;
      `ETH_REGS_IDX_PHY_INDC:      capSlot = 4'd10;
      `ETH_REGS_IDX_PHY_INTR_SRC:  capSlot = 4'd11;
      `ETH_REGS_IDX_PHY_INTR_MSK:  capSlot = 4'd12;
      `ETH_REGS_IDX_PHY_SPEC_CTRL: capSlot = 4'd13;
      // user or unmapped index
      default:                     capHit  = 1'b0;
    endcase
  end

  // ==========================================================================
  // capture
  // ==========================================================================
  // one word per valid strobe
  always_ff @(posedge mdcClk or negedge rstN) begin
    if (!rstN) begin
      phyRegs <= '0;
    end else if (mdioResp.valid && capHit) begin
      phyRegs[capSlot] <= mdioResp.data;
    end
  end

  // read out from axiClk side unsynchronized
  // words only change after a PHY read, then stay put

endmodule

`default_nettype wire

//--- design/regReadMux.sv
// Register read mux
`timescale 1ns/100ps
`default_nettype none

`include "ethRegs_consts.svh"

module regReadMux (
  input  ethRegsPkg::regIdx_t                           rdIdx,
  input  ethRegsPkg::axiData_t [`ETH_REGS_NUM_USR-1:0] usrRegs,
  input  ethRegsPkg::axiData_t [`ETH_REGS_NUM_PHY-1:0] phyRegs,
  output ethRegsPkg::axiData_t                          rData
);

  // latched index, so rData holds while rValid is up
  always_comb begin
    case (rdIdx)
      // PHY shadows
      `ETH_REGS_IDX_PHY_CTRL:      rData = phyRegs[0];
      `ETH_REGS_IDX_PHY_STAT:      rData = phyRegs[1];
      `ETH_REGS_IDX_PHY_IDENT_1:   rData = phyRegs[2];
      `ETH_REGS_IDX_PHY_IDENT_2:   rData = phyRegs[3];
      `ETH_REGS_IDX_PHY_ANA:       rData = phyRegs[4];
      `ETH_REGS_IDX_PHY_ANLP:      rData = phyRegs[5];
      `ETH_REGS_IDX_PHY_ANE:       rData = phyRegs[6];
      `ETH_REGS_IDX_PHY_MODE:      rData = phyRegs[7];
      `ETH_REGS_IDX_PHY_SPEC_MD:   rData = phyRegs[8];
      `ETH_REGS_IDX_PHY_SYM_ERR:   rData = phyRegs[9];
      `ETH_REGS_IDX_PHY_INDC:      rData = phyRegs[10];
      `ETH_REGS_IDX_PHY_INTR_SRC:  rData = phyRegs[11];
      `ETH_REGS_IDX_PHY_INTR_MSK:  rData = phyRegs[12];
      `ETH_REGS_IDX_PHY_SPEC_CTRL: rData = phyRegs[13];
      // user registers, test register included
      `ETH_REGS_IDX_USR_CTRL:      rData = usrRegs[0];
      `ETH_REGS_IDX_USR_WRITE:     rData = usrRegs[1];
      `ETH_REGS_IDX_ETH_TEST:      rData = usrRegs[2];
      // holes in the map
      default:                     rData = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- design/userRegFile.sv
// User register file
`timescale 1ns/100ps
`default_nettype none

`include "ethRegs_consts.svh"

module userRegFile (
  input  logic                                          axiClk,
  input  logic                                          rstN,
  input  ethRegsPkg::regWrite_t                         regWr,
  // slot 0 control, 1 write data, 2 transmit test
  output ethRegsPkg::axiData_t [`ETH_REGS_NUM_USR-1:0] usrRegs,
  output ethRegsPkg::mdioReq_t                          mdioReq,
  output logic                                          ethTxTestEn
);

  // ==========================================================================
  // register writes
  // ==========================================================================
  // other indices fall through untouched
  always_ff @(posedge axiClk or negedge rstN) begin
    if (!rstN) begin
      usrRegs <= '0;
    end else if (regWr.strobe) begin
      case (regWr.idx)
        `ETH_REGS_IDX_USR_CTRL:  usrRegs[0] <= regWr.data;
        `ETH_REGS_IDX_USR_WRITE: usrRegs[1] <= regWr.data;
        `ETH_REGS_IDX_ETH_TEST:  usrRegs[2] <= regWr.data;
        default: begin
        end
      endcase
    end
  end

  // ==========================================================================
  // fields toward MDIO engine
  // ==========================================================================
  // control word split into request fields
  assign mdioReq.regAddr =
    usrRegs[0][`ETH_REGS_CTRL_REG_ADDR_MSB:`ETH_REGS_CTRL_REG_ADDR_LSB];
  assign mdioReq.phyAddr =
    usrRegs[0][`ETH_REGS_CTRL_PHY_ADDR_MSB:`ETH_REGS_CTRL_PHY_ADDR_LSB];
  // 1 = write, 0 = read
  assign mdioReq.isWrite = usrRegs[0][`ETH_REGS_CTRL_WRITE_BIT];
  // kicks off a transaction while high
  assign mdioReq.enable  = usrRegs[0][`ETH_REGS_CTRL_EN_BIT];

  // low half of the write-data register
  assign mdioReq.wrData  = usrRegs[1][`ETH_REGS_MDIO_DATA_W-1:0];

  // test packet generator enable
  assign ethTxTestEn = usrRegs[2][`ETH_REGS_TEST_EN_BIT];

endmodule

`default_nettype wire

//--- dv/ethRegsChecker.sv
// Register block response checker
`timescale 1ns/100ps
`default_nettype none

`include "ethRegs_consts.svh"

module ethRegsChecker (
  input logic                  axiClk,
  input logic                  rstN,
  input logic                  awReady,
  input logic                  arReady,
  input logic                  bValid,
  input logic [1:0]            bResp,
  input logic                  bReady,
  input logic                  rValid,
  input ethRegsPkg::axiData_t  rData,
  input logic [1:0]            rResp,
  input logic                  rReady,
  // high while no acceptance may appear
  input logic                  holdOff
);

  import ethRegsPkg::*;

  int errCount = 0;
  int testCount = 0;
  int testErrStart = 0;
  // responses raised by the DUT
  int bDone = 0;
  int rDone = 0;

  // read data seen on the previous edge
  axiData_t rHeld;
  logic     rWaiting;
  // valid levels on the previous edge
  logic     bPrev;
  logic     rPrev;

  task automatic compare(input string name, input logic [31:0] expVal,
                         input logic [31:0] actVal);
    if (actVal !== expVal) begin
      $display("[ERROR] %s expected %h actual %h", name, expVal, actVal);
      errCount++;
    end
  endtask

  task automatic flagFailure(input string what);
    $display("%s", what);
    errCount++;
  endtask

  // one line per finished test
  task automatic finishTest(input string name);
    testCount++;
    if (errCount == testErrStart) begin
      $display("test %s done, no errors", name);
    end else begin
      $display("test %s done, %0d errors", name, errCount - testErrStart);
    end
    testErrStart = errCount;
  endtask

  task automatic reportCounts();
    $display("%0d tests, %0d writes, %0d reads, %0d errors", testCount, bDone, rDone,
             errCount);
  endtask

  // ==========================================================================
  // port monitor
  // ==========================================================================
  always @(posedge axiClk) begin
    if (!rstN) begin
      rWaiting <= 1'b0;
      bPrev    <= 1'b0;
      rPrev    <= 1'b0;
    end else begin
      if (holdOff && (awReady || arReady)) begin
        flagFailure("an address ready came up while the MDIO engine was busy");
      end
      // a response counts once when its valid rises
      if (bValid && !bPrev) begin
        bDone++;
      end
      if (rValid && !rPrev) begin
        rDone++;
      end
      if (bValid && bReady) begin
        compare("bResp", `ETH_REGS_RESP_OKAY, bResp);
      end
      if (rValid && rReady) begin
        compare("rResp", `ETH_REGS_RESP_OKAY, rResp);
      end
      // rData held while the master stalls
      if (rValid && rWaiting) begin
        compare("rData hold", rHeld, rData);
      end
      rWaiting <= rValid && !rReady;
      rHeld    <= rData;
      bPrev    <= bValid;
      rPrev    <= rValid;
    end
  end

endmodule

`default_nettype wire

//--- dv/ethRegsTb.sv
// Register block testbench
`timescale 1ns/100ps
`default_nettype none

`include "ethRegs_consts.svh"

module ethRegsTb;

  import ethRegsPkg::*;

  localparam int TIMEOUT = 100;

  logic        axiClk;
  logic        mdcClk;
  logic        rstN;
  logic        awValid;
  logic        wValid;
  logic        bReady;
  logic        arValid;
  logic        rReady;
  logic        holdOff;
  logic [`ETH_REGS_AXI_ADDR_W-1:0] awAddr;
  logic [`ETH_REGS_AXI_ADDR_W-1:0] arAddr;
  axiData_t    wData;
  mdioResp_t   mdioResp;
  logic        awReady;
  logic        wReady;
  logic        bValid;
  logic        arReady;
  logic        rValid;
  logic        ethTxTestEn;
  logic [1:0]  bResp;
  logic [1:0]  rResp;
  axiData_t    rData;
  mdioReq_t    mdioReq;

  // expected word per index
  // unmapped indices stay zero
  axiData_t    model [0:63];
  integer      seed;
  int          wrIssued;
  int          rdIssued;
  int          i;
  int          k;
  regIdx_t     idx;
  axiData_t    data;

  always #5 axiClk = ~axiClk;
  always #20 mdcClk = ~mdcClk;

  ethRegs i_ethRegs (
    .axiClk (axiClk), .mdcClk (mdcClk), .rstN (rstN),
    .awValid (awValid), .awReady (awReady), .awAddr (awAddr),
    .wValid (wValid), .wReady (wReady), .wData (wData),
    .bValid (bValid), .bResp (bResp), .bReady (bReady),
    .arValid (arValid), .arReady (arReady), .arAddr (arAddr),
    .rValid (rValid), .rData (rData), .rResp (rResp), .rReady (rReady),
    .mdioReq (mdioReq), .mdioResp (mdioResp), .ethTxTestEn (ethTxTestEn)
  );

  ethRegsChecker i_ethRegsChecker (
    .axiClk (axiClk), .rstN (rstN), .awReady (awReady), .arReady (arReady),
    .bValid (bValid), .bResp (bResp), .bReady (bReady),
    .rValid (rValid), .rData (rData), .rResp (rResp), .rReady (rReady),
    .holdOff (holdOff)
  );

  function automatic logic phyMapped(input regIdx_t idx);
    case (idx)
      6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06,
      6'h11, 6'h12, 6'h1A, 6'h1B, 6'h1D, 6'h1E, 6'h1F: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic userMapped(input regIdx_t idx);
    return (idx == `ETH_REGS_IDX_USR_CTRL) || (idx == `ETH_REGS_IDX_USR_WRITE) ||
           (idx == `ETH_REGS_IDX_ETH_TEST);
  endfunction

  // ==========================================================================
  // AXI master
  // ==========================================================================
  task automatic writeReg(input regIdx_t idx, input axiData_t data, input int delay);
    int n;
    @(posedge axiClk);
    awValid <= 1'b1;
    wValid  <= 1'b1;
    awAddr  <= {24'h0, idx, 2'b00};
    wData   <= data;
    n = 0;
    do begin
      @(posedge axiClk);
      n++;
    end while (!(awReady && wReady) && n < TIMEOUT);
    awValid <= 1'b0;
    wValid  <= 1'b0;
    n = 0;
    while (!bValid && n < TIMEOUT) begin
      @(posedge axiClk);
      n++;
    end
    if (!bValid) begin
      i_ethRegsChecker.flagFailure($sformatf("timeout on write to index %h", idx));
    end else begin
      wrIssued++;
      // unmapped writes change nothing
      if (userMapped(idx)) model[idx] = data;
      repeat (delay) begin
        @(posedge axiClk);
        if (!bValid) i_ethRegsChecker.flagFailure("bValid dropped before bReady");
      end
      bReady <= 1'b1;
      @(posedge axiClk);
      bReady <= 1'b0;
    end
  endtask

  task automatic readAndCompare(input string name, input regIdx_t idx, input int delay);
    int n;
    @(posedge axiClk);
    arValid <= 1'b1;
    arAddr  <= {24'h0, idx, 2'b00};
    n = 0;
    do begin
      @(posedge axiClk);
      n++;
    end while (!arReady && n < TIMEOUT);
    arValid <= 1'b0;
    n = 0;
    while (!rValid && n < TIMEOUT) begin
      @(posedge axiClk);
      n++;
    end
    if (!rValid) begin
      i_ethRegsChecker.flagFailure($sformatf("timeout on read of index %h", idx));
    end else begin
      rdIssued++;
      i_ethRegsChecker.compare($sformatf("%s idx %h", name, idx), model[idx], rData);
      repeat (delay) begin
        @(posedge axiClk);
        if (!rValid) i_ethRegsChecker.flagFailure("rValid dropped before rReady");
      end
      rReady <= 1'b1;
      @(posedge axiClk);
      rReady <= 1'b0;
    end
  endtask

  task automatic readAllMapped(input string name);
    for (int j = 0; j < 64; j++) begin
      if (phyMapped(j) || userMapped(j)) readAndCompare(name, j, 0);
    end
  endtask

  // one-cycle strobe in the mdcClk domain
  task automatic mdioStrobe(input regIdx_t idx, input axiData_t data);
    @(posedge mdcClk);
    mdioResp.valid  <= 1'b1;
    mdioResp.regIdx <= idx;
    mdioResp.data   <= data;
    if (phyMapped(idx)) model[idx] = data;
    @(posedge mdcClk);
    mdioResp.valid <= 1'b0;
  endtask

  // request fields from the control and write-data words
  task automatic checkDriven(input string name);
    axiData_t ctrl;
    axiData_t test;
    mdioReq_t expReq;
    ctrl = model[`ETH_REGS_IDX_USR_CTRL];
    test = model[`ETH_REGS_IDX_ETH_TEST];
    expReq.regAddr = ctrl[`ETH_REGS_CTRL_REG_ADDR_MSB:`ETH_REGS_CTRL_REG_ADDR_LSB];
    expReq.phyAddr = ctrl[`ETH_REGS_CTRL_PHY_ADDR_MSB:`ETH_REGS_CTRL_PHY_ADDR_LSB];
    expReq.isWrite = ctrl[`ETH_REGS_CTRL_WRITE_BIT];
    expReq.enable  = ctrl[`ETH_REGS_CTRL_EN_BIT];
    expReq.wrData  = model[`ETH_REGS_IDX_USR_WRITE][15:0];
    i_ethRegsChecker.compare({name, " mdioReq"}, {4'h0, expReq}, {4'h0, mdioReq});
    i_ethRegsChecker.compare({name, " ethTxTestEn"}, test[`ETH_REGS_TEST_EN_BIT],
                             ethTxTestEn);
  endtask

  function automatic regIdx_t unmappedIdx();
    regIdx_t idx;
    idx = $random(seed);
    while (phyMapped(idx) || userMapped(idx)) idx = idx + 6'd1;
    return idx;
  endfunction

  // ==========================================================================
  // test sequence
  // ==========================================================================
  initial begin
    axiClk = 1'b0;
    mdcClk = 1'b0;
    rstN = 1'b0;
    awValid = 1'b0;
    wValid = 1'b0;
    bReady = 1'b0;
    arValid = 1'b0;
    rReady = 1'b0;
    holdOff = 1'b0;
    awAddr = '0;
    arAddr = '0;
    wData = '0;
    mdioResp = '0;
    seed = 32'haea90f9f;
    wrIssued = 0;
    rdIssued = 0;
    for (i = 0; i < 64; i++) model[i] = '0;
    repeat (8) @(posedge axiClk);
    rstN <= 1'b1;
    @(posedge axiClk);
    i_ethRegsChecker.compare("reset handshake outputs", 0,
                             {awReady, wReady, bValid, arReady, rValid});
    checkDriven("reset");
    readAllMapped("reset read");
    i_ethRegsChecker.finishTest("reset state");

    repeat (12) begin
      idx = `ETH_REGS_IDX_USR_CTRL + ($unsigned($random(seed)) % 3);
      writeReg(idx, $random(seed), 0);
      checkDriven("user write");
      readAndCompare("user readback", idx, 0);
    end
    i_ethRegsChecker.finishTest("user registers");

    // strobes at any index including user ones and holes
    repeat (24) begin
      idx = $random(seed);
      mdioStrobe(idx, $random(seed));
    end
    readAllMapped("phy capture");
    i_ethRegsChecker.finishTest("phy capture");

    repeat (8) begin
      idx = unmappedIdx();
      writeReg(idx, $random(seed), 0);
      readAndCompare("unmapped read", idx, 0);
    end
    readAllMapped("after unmapped");
    i_ethRegsChecker.finishTest("unmapped addresses");

    // a write and then a read held off by busy
    for (k = 0; k < 2; k++) begin
      data = $random(seed);
      @(posedge mdcClk);
      mdioResp.busy <= 1'b1;
      repeat (4) @(posedge axiClk);
      holdOff <= 1'b1;
      fork
        if (k == 0) writeReg(`ETH_REGS_IDX_USR_WRITE, data, 0);
        else readAndCompare("busy read", `ETH_REGS_IDX_USR_WRITE, 0);
        begin
          repeat (24) @(posedge axiClk);
          @(posedge mdcClk);
          mdioResp.busy <= 1'b0;
          holdOff <= 1'b0;
        end
      join
    end
    checkDriven("busy write");
    i_ethRegsChecker.finishTest("busy hold-off");

    repeat (10) begin
      idx = `ETH_REGS_IDX_USR_CTRL + ($unsigned($random(seed)) % 3);
      writeReg(idx, $random(seed), $unsigned($random(seed)) % 8);
      readAndCompare("stalled read", idx, $unsigned($random(seed)) % 8);
    end
    i_ethRegsChecker.compare("write count", wrIssued, i_ethRegsChecker.bDone);
    i_ethRegsChecker.compare("read count", rdIssued, i_ethRegsChecker.rDone);
    i_ethRegsChecker.finishTest("back-pressure");

    i_ethRegsChecker.reportCounts();
    if (i_ethRegsChecker.errCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ethRegs.f
+incdir+include
design/ethRegsPkg.sv
design/axiLiteSlave.sv
design/userRegFile.sv
design/phyShadowRegs.sv
design/regReadMux.sv
design/ethRegs.sv
dv/ethRegsChecker.sv
dv/ethRegsTb.sv

//--- include/ethRegs_consts.svh
// Ethernet register map constants
`ifndef ETH_REGS_CONSTS_SVH
`define ETH_REGS_CONSTS_SVH

// bus widths
`define ETH_REGS_AXI_DATA_W  32
`define ETH_REGS_AXI_ADDR_W  32
// word index taken from byte address
`define ETH_REGS_IDX_LSB     2
`define ETH_REGS_IDX_MSB     7
`define ETH_REGS_IDX_W       6
`define ETH_REGS_PHY_ADDR_W  5
`define ETH_REGS_MDIO_DATA_W 16
`define ETH_REGS_RESP_OKAY   2'b00

// register counts per group
`define ETH_REGS_NUM_PHY 14
`define ETH_REGS_NUM_USR 3

// PHY shadow indices, same numbers as the PHY's own map
`define ETH_REGS_IDX_PHY_CTRL      6'h00
`define ETH_REGS_IDX_PHY_STAT      6'h01
`define ETH_REGS_IDX_PHY_IDENT_1   6'h02
`define ETH_REGS_IDX_PHY_IDENT_2   6'h03
`define ETH_REGS_IDX_PHY_ANA       6'h04
`define ETH_REGS_IDX_PHY_ANLP      6'h05
`define ETH_REGS_IDX_PHY_ANE       6'h06
`define ETH_REGS_IDX_PHY_MODE      6'h11
`define ETH_REGS_IDX_PHY_SPEC_MD   6'h12
`define ETH_REGS_IDX_PHY_SYM_ERR   6'h1A
`define ETH_REGS_IDX_PHY_INDC      6'h1B
`define ETH_REGS_IDX_PHY_INTR_SRC  6'h1D
`define ETH_REGS_IDX_PHY_INTR_MSK  6'h1E
`define ETH_REGS_IDX_PHY_SPEC_CTRL 6'h1F

// user registers
`define ETH_REGS_IDX_USR_CTRL  6'h20
`define ETH_REGS_IDX_USR_WRITE 6'h21
`define ETH_REGS_IDX_ETH_TEST  6'h22

// fields of the user control word
`define ETH_REGS_CTRL_REG_ADDR_MSB 11
`define ETH_REGS_CTRL_REG_ADDR_LSB 7
`define ETH_REGS_CTRL_PHY_ADDR_MSB 6
`define ETH_REGS_CTRL_PHY_ADDR_LSB 2
`define ETH_REGS_CTRL_WRITE_BIT    1
`define ETH_REGS_CTRL_EN_BIT       0
// transmit test enable in the test register
`define ETH_REGS_TEST_EN_BIT       0

`endif
